// File: project.f
source/decode_pkg.sv
source/rv64i_decoder.sv
source/dispatch_fifo.sv
source/decode_regs_apb.sv
source/decode_stage.sv
verification/decode_stage_sva.sv
verification/decode_stage_tb.sv

// File: source/decode_pkg.sv
//******************************
// micro-op record, operation classes and APB register offsets
// of the decode stage; offsets are byte addresses on a 4-bit bus
//******************************
package decode_pkg;

	// operation class of a decoded word
	typedef enum logic [4:0] {
		OP_ALU       = 5'd0,
		OP_ALU_IMM   = 5'd1,
		OP_ALU_W     = 5'd2,
		OP_ALU_IMM_W = 5'd3,
		OP_LOAD      = 5'd4,
		OP_STORE     = 5'd5,
		OP_BRANCH    = 5'd6,
		OP_JAL       = 5'd7,
		OP_JALR      = 5'd8,
		OP_LUI       = 5'd9,
		OP_AUIPC     = 5'd10,
		OP_FENCE     = 5'd11,
		OP_FENCE_I   = 5'd12,
		OP_ECALL     = 5'd13,
		OP_EBREAK    = 5'd14,
		OP_CSR       = 5'd15,
		OP_ILLEGAL   = 5'd16
	} op_class_e;

	// decoded record handed to dispatch
	typedef struct packed {
		op_class_e   op_class;
		// load width, branch condition, alu function or csr op
		logic [2:0]  funct3;
		// instr[30] for sub/sra style ops, zero otherwise
		logic        alt;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		// sign-extended, zero for register-register ops
		logic [63:0] imm;
	} micro_op_t;

	// register block offsets
	localparam logic [3:0] ADDR_CTRL    = 4'h0;
	localparam logic [3:0] ADDR_DECODED = 4'h4;
	localparam logic [3:0] ADDR_ILLEGAL = 4'h8;
	localparam logic [3:0] ADDR_LEVEL   = 4'hC;

	// bit positions inside CTRL
	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_DROP_BIT   = 1;

endpackage

// File: source/decode_regs_apb.sv
//******************************
// APB slave for decode control, no wait states
// misaligned offsets and writes to LEVEL raise pslverr
//******************************
`timescale 1ns/1ns

module decode_regs_apb import decode_pkg::*; (
	input  logic        CLK,
	input  logic        reset,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	input  logic        decoded_event,
	input  logic        illegal_event,
	input  logic [4:0]  level,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        enable,
	output logic        drop_illegal
);

	logic        access;
	logic        addr_err;
	logic        wr_en;
	logic [1:0]  ctrl;
	logic [31:0] decoded_cnt;
	logic [31:0] illegal_cnt;

	// saturating increment, stays at all ones
	function automatic logic [31:0] sat_inc(input logic [31:0] cnt, input logic ev);
		if (ev && cnt != 32'hffff_ffff)
			return cnt + 32'd1;
		return cnt;
	endfunction

	assign access = psel & penable;

	// only 4 address bits, so the aligned offsets stop at 0xC
	assign addr_err = (paddr[1:0] != 2'b00) || (pwrite && paddr == ADDR_LEVEL);
	assign pslverr  = access & addr_err;
	assign pready   = 1'b1;
	assign wr_en    = access & pwrite & ~addr_err;

	assign enable       = ctrl[CTRL_ENABLE_BIT];
	assign drop_illegal = ctrl[CTRL_DROP_BIT];

	always_ff @(posedge CLK) begin
		if (reset) begin
			ctrl <= 2'b00;
			decoded_cnt <= 32'd0;
			illegal_cnt <= 32'd0;
		end else begin
			if (wr_en && paddr == ADDR_CTRL)
				ctrl <= pwdata[1:0];
			// a clear beats an event in the same cycle
			if (wr_en && paddr == ADDR_DECODED)
				decoded_cnt <= 32'd0;
			else
				decoded_cnt <= sat_inc(decoded_cnt, decoded_event);
			if (wr_en && paddr == ADDR_ILLEGAL)
				illegal_cnt <= 32'd0;
			else
				illegal_cnt <= sat_inc(illegal_cnt, illegal_event);
		end
	end

	always_comb begin
		prdata = 32'd0;
		if (access && !pwrite && !addr_err) begin
			case (paddr)
				ADDR_CTRL:    prdata = {30'd0, ctrl};
				ADDR_DECODED: prdata = decoded_cnt;
				ADDR_ILLEGAL: prdata = illegal_cnt;
				ADDR_LEVEL:   prdata = {27'd0, level};
				default:      prdata = 32'd0;
			endcase
		end
	end

endmodule

// File: source/decode_stage.sv
//******************************
// decode stage top: decoder, dispatch FIFO, APB registers
// decoder stays idle until software sets CTRL.enable
//******************************
`timescale 1ns/1ns

module decode_stage import decode_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic        CLK,
	input  logic        reset,
	input  logic        fetch_valid,
	input  logic [31:0] fetch_instr,
	output logic        fetch_ready,
	output logic        dispatch_valid,
	output micro_op_t   dispatch_op,
	input  logic        dispatch_ready,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	logic      push;
	micro_op_t push_data;
	logic      full;
	logic [4:0] level;
	logic      enable;
	logic      drop_illegal;
	logic      decoded_event;
	logic      illegal_event;

	rv64i_decoder u_decoder (
		.fetch_valid   (fetch_valid),
		.fetch_instr   (fetch_instr),
		.full          (full),
		.enable        (enable),
		.drop_illegal  (drop_illegal),
		.fetch_ready   (fetch_ready),
		.push          (push),
		.push_data     (push_data),
		.decoded_event (decoded_event),
		.illegal_event (illegal_event)
	);

	dispatch_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.CLK            (CLK),
		.reset          (reset),
		.push           (push),
		.push_data      (push_data),
		.dispatch_ready (dispatch_ready),
		.full           (full),
		.level          (level),
		.dispatch_valid (dispatch_valid),
		.dispatch_op    (dispatch_op)
	);

	decode_regs_apb u_regs (
		.CLK           (CLK),
		.reset         (reset),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.decoded_event (decoded_event),
		.illegal_event (illegal_event),
		.level         (level),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr),
		.enable        (enable),
		.drop_illegal  (drop_illegal)
	);

endmodule

// File: source/dispatch_fifo.sv
//******************************
// micro-op FIFO, FIFO_DEPTH a power of two up to 16
// push is not checked against full, the decoder does that
//******************************
`timescale 1ns/1ns

module dispatch_fifo import decode_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic      CLK,
	input  logic      reset,
	input  logic      push,
	input  micro_op_t push_data,
	input  logic      dispatch_ready,
	output logic      full,
	output logic [4:0] level,
	output logic      dispatch_valid,
	output micro_op_t dispatch_op
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	micro_op_t      mem [FIFO_DEPTH];
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic [PTR_W:0] count;
	logic           pop;

	// extra msb tells full from empty when the index bits match
	assign count          = wr_ptr - rd_ptr;
	assign full           = (count == (PTR_W + 1)'(FIFO_DEPTH));
	assign level          = 5'(count);
	assign dispatch_valid = (count != '0);
	assign pop            = dispatch_valid & dispatch_ready;

	assign dispatch_op = mem[rd_ptr[PTR_W-1:0]];

	always_ff @(posedge CLK) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// storage
	always_ff @(posedge CLK) begin
		if (push)
			mem[wr_ptr[PTR_W-1:0]] <= push_data;
	end

endmodule

// File: source/rv64i_decoder.sv
//******************************
// RV64I + Zifencei + Zicsr decoder, purely combinational
// no RVC, FP, atomics; unknown encodings become OP_ILLEGAL
// fetch_ready already includes fetch_valid
//******************************
`timescale 1ns/1ns

module rv64i_decoder import decode_pkg::*; (
	input  logic        fetch_valid,
	input  logic [31:0] fetch_instr,
	input  logic        full,
	input  logic        enable,
	input  logic        drop_illegal,
	output logic        fetch_ready,
	output logic        push,
	output micro_op_t   push_data,
	output logic        decoded_event,
	output logic        illegal_event
);

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [63:0] imm_i;
	logic [63:0] imm_s;
	logic [63:0] imm_b;
	logic [63:0] imm_u;
	logic [63:0] imm_j;
	logic        shift6_ok;
	logic        funct7_ok;
	op_class_e   op_class;
	logic [63:0] imm;
	logic        alt;
	logic        is_illegal;

	assign opcode = fetch_instr[6:0];
	assign funct3 = fetch_instr[14:12];
	assign funct7 = fetch_instr[31:25];

	assign imm_i = {{52{fetch_instr[31]}}, fetch_instr[31:20]};
	assign imm_s = {{52{fetch_instr[31]}}, fetch_instr[31:25], fetch_instr[11:7]};
	assign imm_b = {{52{fetch_instr[31]}}, fetch_instr[7], fetch_instr[30:25],
		fetch_instr[11:8], 1'b0};
	assign imm_u = {{32{fetch_instr[31]}}, fetch_instr[31:12], 12'b0};
	assign imm_j = {{44{fetch_instr[31]}}, fetch_instr[19:12], fetch_instr[20],
		fetch_instr[30:21], 1'b0};

	// 64-bit shifts use a 6-bit shamt, so only instr[31:26] is checked
	assign shift6_ok = (fetch_instr[31:26] == 6'b000000) || (fetch_instr[31:26] == 6'b010000);
	assign funct7_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);

	always_comb begin
		op_class = OP_ILLEGAL;
		imm = 64'd0;
		alt = 1'b0;
		if (opcode[1:0] == 2'b11) begin
			case (opcode[6:2])
				5'b01101: begin
					op_class = OP_LUI;
					imm = imm_u;
				end
				5'b00101: begin
					op_class = OP_AUIPC;
					imm = imm_u;
				end
				5'b11011: begin
					op_class = OP_JAL;
					imm = imm_j;
				end
				5'b11001: if (funct3 == 3'b000) begin
					op_class = OP_JALR;
					imm = imm_i;
				end
				// funct3 010 and 011 are reserved for branches
				5'b11000: if (funct3[2:1] != 2'b01) begin
					op_class = OP_BRANCH;
					imm = imm_b;
				end
				5'b00000: if (funct3 != 3'b111) begin
					op_class = OP_LOAD;
					imm = imm_i;
				end
				5'b01000: if (funct3[2] == 1'b0) begin
					op_class = OP_STORE;
					imm = imm_s;
				end
				5'b00100: begin
					if ((funct3 != 3'b001 && funct3 != 3'b101) ||
						(funct3 == 3'b001 && fetch_instr[31:26] == 6'b000000) ||
						(funct3 == 3'b101 && shift6_ok)) begin
						op_class = OP_ALU_IMM;
						imm = imm_i;
						alt = (funct3 == 3'b101) & fetch_instr[30];
					end
				end
				5'b00110: begin
					if (funct3 == 3'b000 || (funct3 == 3'b001 && funct7 == 7'b0000000) ||
						(funct3 == 3'b101 && funct7_ok)) begin
						op_class = OP_ALU_IMM_W;
						imm = imm_i;
						alt = (funct3 == 3'b101) & fetch_instr[30];
					end
				end
				5'b01100: begin
					if (funct7 == 7'b0000000 ||
						(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
						op_class = OP_ALU;
						alt = fetch_instr[30];
					end
				end
				5'b01110: begin
					if ((funct3 == 3'b000 || funct3 == 3'b101) ? funct7_ok :
						(funct3 == 3'b001 && funct7 == 7'b0000000)) begin
						op_class = OP_ALU_W;
						alt = fetch_instr[30];
					end
				end
				5'b00011: begin
					if (funct3 == 3'b000) begin
						op_class = OP_FENCE;
						imm = imm_i;
					end else if (funct3 == 3'b001) begin
						op_class = OP_FENCE_I;
						imm = imm_i;
					end
				end
				5'b11100: begin
					if (fetch_instr[31:7] == 25'd0) begin
						op_class = OP_ECALL;
						imm = imm_i;
					end else if (fetch_instr[31:7] == {12'd1, 13'd0}) begin
						op_class = OP_EBREAK;
						imm = imm_i;
					end else if (funct3[1:0] != 2'b00) begin
						// csr address lands in the immediate
						op_class = OP_CSR;
						imm = imm_i;
					end
				end
				default: op_class = OP_ILLEGAL;
			endcase
		end
	end

	assign is_illegal = (op_class == OP_ILLEGAL);

	assign push_data.op_class = op_class;
	assign push_data.funct3   = funct3;
	assign push_data.alt      = alt;
	assign push_data.rd       = fetch_instr[11:7];
	assign push_data.rs1      = fetch_instr[19:15];
	assign push_data.rs2      = fetch_instr[24:20];
	assign push_data.imm      = imm;

	// ready doubles as the accept strobe
	assign fetch_ready   = enable & ~full & fetch_valid;
	assign push          = fetch_ready & ~(is_illegal & drop_illegal);
	assign decoded_event = fetch_ready & ~is_illegal;
	assign illegal_event = fetch_ready & is_illegal;

endmodule

// File: verification/decode_stage_sva.sv
//******************************
// handshake and FIFO assertions, bound into decode_stage
// disabled while reset is high
//******************************
`timescale 1ns/1ns

module decode_stage_sva import decode_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input logic        CLK,
	input logic        reset,
	input logic        fetch_valid,
	input logic [31:0] fetch_instr,
	input logic        fetch_ready,
	input logic        dispatch_valid,
	input logic        dispatch_ready,
	input micro_op_t   dispatch_op,
	input logic        full,
	input logic [4:0]  level
);

	// fetch keeps the word steady until it is taken
	a_fetch_hold: assert property (@(posedge CLK) disable iff (reset)
		fetch_valid && !fetch_ready |=> $stable(fetch_instr))
		else $error("fetch_instr changed while fetch_valid waited for fetch_ready");

	a_dispatch_hold: assert property (@(posedge CLK) disable iff (reset)
		dispatch_valid && !dispatch_ready |=> dispatch_valid && $stable(dispatch_op))
		else $error("dispatch_op changed while dispatch_valid waited for dispatch_ready");

	a_no_ready_full: assert property (@(posedge CLK) disable iff (reset) !(fetch_ready && full))
		else $error("fetch_ready high while the FIFO is full");

	a_level_max: assert property (@(posedge CLK) disable iff (reset) level <= FIFO_DEPTH)
		else $error("FIFO level above its depth");

endmodule

bind decode_stage decode_stage_sva #(
	.FIFO_DEPTH (FIFO_DEPTH)
) u_sva (
	.CLK            (CLK),
	.reset          (reset),
	.fetch_valid    (fetch_valid),
	.fetch_instr    (fetch_instr),
	.fetch_ready    (fetch_ready),
	.dispatch_valid (dispatch_valid),
	.dispatch_ready (dispatch_ready),
	.dispatch_op    (dispatch_op),
	.full           (full),
	.level          (level)
);

// File: verification/decode_stage_tb.sv
//******************************
// decode_stage testbench, xorshift stimulus with fixed seed
// reference decoder model checks the dispatch stream in order
// register checks run only while fetch is idle
//******************************
`timescale 1ns/1ns

module decode_stage_tb import decode_pkg::*; ();

	localparam int FIFO_DEPTH = 4;
	localparam int TIMEOUT = 1000;
	localparam logic [31:0] SEED = 32'h16e5cbcd;

	logic        CLK;
	logic        reset;
	logic        fetch_valid;
	logic [31:0] fetch_instr;
	logic        fetch_ready;
	logic        dispatch_valid;
	micro_op_t   dispatch_op;
	logic        dispatch_ready;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	logic [31:0] rng_state;
	micro_op_t   expq [$];
	logic [1:0]  ctrl_model;
	logic [16:0] class_seen = '0;
	int          legal_cnt = 0;
	int          illegal_cnt = 0;
	int          op_errors = 0;
	int          reg_errors = 0;
	int          flag_errors = 0;
	int          other_errors = 0;

	decode_stage #(.FIFO_DEPTH(FIFO_DEPTH)) DUT (.*);

	initial CLK = 1'b0;
	always #5 CLK = ~CLK;

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// one legal encoding of kind k, other fields taken from r
	function automatic logic [31:0] make_legal(input logic [3:0] k, input logic [31:0] r);
		logic [2:0]  f3;
		logic [2:0]  f3w;
		logic [6:0]  f7;
		logic [31:0] w;
		f3 = r[14:12];
		f3w = (r[13:12] == 2'd0) ? 3'd0 : (r[13:12] == 2'd1) ? 3'd1 : 3'd5;
		case (k)
			4'd0: w = {r[31:7], 7'h37};
			4'd1: w = {r[31:7], 7'h17};
			4'd2: w = {r[31:7], 7'h6f};
			4'd3: w = {r[31:15], 3'd0, r[11:7], 7'h67};
			4'd4: w = {r[31:15], (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3, r[11:7], 7'h63};
			4'd5: w = {r[31:15], (f3 == 3'd7) ? 3'd6 : f3, r[11:7], 7'h03};
			4'd6: w = {r[31:15], 1'b0, r[13:12], r[11:7], 7'h23};
			4'd7: begin
				if (f3 == 3'd1)
					w = {6'h00, r[25:15], f3, r[11:7], 7'h13};
				else if (f3 == 3'd5)
					w = {1'b0, r[30], 4'h0, r[25:15], f3, r[11:7], 7'h13};
				else
					w = {r[31:15], f3, r[11:7], 7'h13};
			end
			4'd8: begin
				f7 = (f3w == 3'd0) ? r[31:25] : (f3w == 3'd5) ? {1'b0, r[30], 5'h0} : 7'h00;
				w = {f7, r[24:15], f3w, r[11:7], 7'h1b};
			end
			4'd9: begin
				f7 = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, r[30], 5'h0} : 7'h00;
				w = {f7, r[24:15], f3, r[11:7], 7'h33};
			end
			4'd10: begin
				f7 = (f3w == 3'd1) ? 7'h00 : {1'b0, r[30], 5'h0};
				w = {f7, r[24:15], f3w, r[11:7], 7'h3b};
			end
			4'd11: w = {r[31:15], 3'd0, r[11:7], 7'h0f};
			4'd12: w = {r[31:15], 3'd1, r[11:7], 7'h0f};
			4'd13: w = 32'h0000_0073;
			4'd14: w = 32'h0010_0073;
			default: w = {r[31:15], f3[2], f3[1], f3[0] | ~f3[1], r[11:7], 7'h73};
		endcase
		return w;
	endfunction

	// roughly one word in five is fully random
	function automatic logic [31:0] gen_word();
		logic [31:0] k;
		if (next_rand() % 5 == 0)
			return next_rand();
		k = next_rand();
		return make_legal(k[3:0], next_rand());
	endfunction

	function automatic micro_op_t with_class(input micro_op_t m, input op_class_e c,
		input logic [63:0] imm);
		m.op_class = c;
		m.imm = imm;
		return m;
	endfunction

	// reference decode, field layout of the RV64I base spec
	function automatic micro_op_t ref_decode(input logic [31:0] w);
		micro_op_t          m;
		logic signed [63:0] imm_i;
		logic signed [63:0] imm_s;
		logic signed [63:0] imm_b;
		logic signed [63:0] imm_u;
		logic signed [63:0] imm_j;
		logic [2:0]         f3;
		logic [6:0]         f7;
		logic               f7_ok;
		f3 = w[14:12];
		f7 = w[31:25];
		f7_ok = (f7 == 7'h00) || (f7 == 7'h20);
		imm_i = $signed(w[31:20]);
		imm_s = $signed({w[31:25], w[11:7]});
		imm_b = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
		imm_u = $signed({w[31:12], 12'h000});
		imm_j = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
		m = '{op_class: OP_ILLEGAL, funct3: f3, alt: 1'b0, rd: w[11:7], rs1: w[19:15],
			rs2: w[24:20], imm: 64'd0};
		case (w[6:0])
			7'h37: m = with_class(m, OP_LUI, imm_u);
			7'h17: m = with_class(m, OP_AUIPC, imm_u);
			7'h6f: m = with_class(m, OP_JAL, imm_j);
			7'h67: if (f3 == 3'd0) m = with_class(m, OP_JALR, imm_i);
			7'h63: if (f3 != 3'd2 && f3 != 3'd3) m = with_class(m, OP_BRANCH, imm_b);
			7'h03: if (f3 != 3'd7) m = with_class(m, OP_LOAD, imm_i);
			7'h23: if (f3 < 3'd4) m = with_class(m, OP_STORE, imm_s);
			7'h13: if ((f3 == 3'd1) ? (w[31:26] == 6'h00) :
				(f3 != 3'd5 || w[31:26] == 6'h00 || w[31:26] == 6'h10)) begin
				m = with_class(m, OP_ALU_IMM, imm_i);
				m.alt = (f3 == 3'd5) && w[30];
			end
			7'h1b: if (f3 == 3'd0 || (f3 == 3'd1 && f7 == 7'h00) || (f3 == 3'd5 && f7_ok)) begin
				m = with_class(m, OP_ALU_IMM_W, imm_i);
				m.alt = (f3 == 3'd5) && w[30];
			end
			7'h33: if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
				m = with_class(m, OP_ALU, 64'd0);
				m.alt = (f7 == 7'h20);
			end
			7'h3b: if (((f3 == 3'd0 || f3 == 3'd5) && f7_ok) || (f3 == 3'd1 && f7 == 7'h00)) begin
				m = with_class(m, OP_ALU_W, 64'd0);
				m.alt = (f7 == 7'h20);
			end
			7'h0f: begin
				if (f3 == 3'd0)
					m = with_class(m, OP_FENCE, imm_i);
				else if (f3 == 3'd1)
					m = with_class(m, OP_FENCE_I, imm_i);
			end
			7'h73: begin
				if (w == 32'h0000_0073)
					m = with_class(m, OP_ECALL, imm_i);
				else if (w == 32'h0010_0073)
					m = with_class(m, OP_EBREAK, imm_i);
				else if (f3[1:0] != 2'b00)
					m = with_class(m, OP_CSR, imm_i);
			end
			default: ;
		endcase
		return m;
	endfunction

	task automatic check_op(input micro_op_t exp, input micro_op_t got);
		if (got.op_class !== exp.op_class)
			$display("Error dispatch_op.op_class: expected %h, got %h", exp.op_class, got.op_class);
		if (got.funct3 !== exp.funct3)
			$display("Error dispatch_op.funct3: expected %h, got %h", exp.funct3, got.funct3);
		if (got.alt !== exp.alt)
			$display("Error dispatch_op.alt: expected %h, got %h", exp.alt, got.alt);
		if (got.rd !== exp.rd)
			$display("Error dispatch_op.rd: expected %h, got %h", exp.rd, got.rd);
		if (got.rs1 !== exp.rs1)
			$display("Error dispatch_op.rs1: expected %h, got %h", exp.rs1, got.rs1);
		if (got.rs2 !== exp.rs2)
			$display("Error dispatch_op.rs2: expected %h, got %h", exp.rs2, got.rs2);
		if (got.imm !== exp.imm)
			$display("Error dispatch_op.imm: expected %h, got %h", exp.imm, got.imm);
		if (got !== exp)
			op_errors++;
	endtask

	task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			$display("Error %s: expected %h, got %h", name, exp, got);
			reg_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("Error %s: expected %h, got %h", name, exp, got);
			flag_errors++;
		end
	endtask

	task automatic finish_run();
		$display("Summary: op=%0d reg=%0d flag=%0d other=%0d errors",
			op_errors, reg_errors, flag_errors, other_errors);
		if (op_errors + reg_errors + flag_errors + other_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout: %s", what);
		other_errors++;
		finish_run();
	endtask

	task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic err);
		int n;
		@(posedge CLK);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= data;
		@(posedge CLK);
		penable <= 1'b1;
		@(negedge CLK);
		n = 0;
		while (!pready && n < TIMEOUT) begin
			@(negedge CLK);
			n++;
		end
		if (!pready)
			fail_timeout("APB slave never raised pready");
		rdata = prdata;
		err = pslverr;
		@(posedge CLK);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data, input logic exp_err);
		logic [31:0] rdata;
		logic        err;
		apb_access(1'b1, addr, data, rdata, err);
		check_bit("pslverr", exp_err, err);
	endtask

	task automatic read_reg(input logic [3:0] addr, input string name, input logic [31:0] exp,
		input logic exp_err);
		logic [31:0] rdata;
		logic        err;
		apb_access(1'b0, addr, 32'd0, rdata, err);
		check_bit("pslverr", exp_err, err);
		if (!exp_err)
			check_reg(name, exp, rdata);
	endtask

	task automatic record_accept(input logic [31:0] w);
		micro_op_t m;
		m = ref_decode(w);
		class_seen[m.op_class] = 1'b1;
		if (m.op_class == OP_ILLEGAL) begin
			illegal_cnt++;
			if (!ctrl_model[1])
				expq.push_back(m);
		end else begin
			legal_cnt++;
			expq.push_back(m);
		end
	endtask

	// one cycle of observation at the falling edge
	task automatic sample_cycle(output logic take);
		micro_op_t exp;
		@(negedge CLK);
		if (dispatch_valid && dispatch_ready) begin
			if (expq.size() == 0) begin
				$display("Micro-op dispatched while no accepted word was pending");
				other_errors++;
			end else begin
				exp = expq.pop_front();
				check_op(exp, dispatch_op);
			end
		end
		take = fetch_valid && fetch_ready;
		if (take)
			record_accept(fetch_instr);
	endtask

	// mode 0 ready high, 1 ready random, 2 ready low
	task automatic run_stream(input int n, input int mode);
		int          sent;
		int          stall;
		logic        take;
		logic [31:0] r;
		sent = 0;
		stall = 0;
		while (sent < n) begin
			sample_cycle(take);
			if (take) begin
				sent++;
				stall = 0;
			end else if (fetch_valid) begin
				stall++;
				if (stall > TIMEOUT)
					fail_timeout("fetch word was never accepted");
			end
			@(posedge CLK);
			r = next_rand();
			dispatch_ready <= (mode == 0) ? 1'b1 : (mode == 1) ? r[0] : 1'b0;
			if (take || !fetch_valid) begin
				r = next_rand();
				fetch_valid <= (sent < n) && (r[1:0] != 2'b00);
				fetch_instr <= gen_word();
			end
		end
	endtask

	// also takes a word still waiting on fetch
	task automatic drain();
		int   n;
		logic take;
		n = 0;
		while (n <= TIMEOUT) begin
			sample_cycle(take);
			if (!fetch_valid && expq.size() == 0 && !dispatch_valid)
				break;
			@(posedge CLK);
			dispatch_ready <= 1'b1;
			if (take)
				fetch_valid <= 1'b0;
			n++;
		end
		if (n > TIMEOUT)
			fail_timeout("dispatch FIFO did not drain");
	endtask

	task automatic check_counters();
		read_reg(ADDR_DECODED, "DECODED", 32'(legal_cnt), 1'b0);
		read_reg(ADDR_ILLEGAL, "ILLEGAL", 32'(illegal_cnt), 1'b0);
		write_reg(ADDR_DECODED, next_rand(), 1'b0);
		write_reg(ADDR_ILLEGAL, next_rand(), 1'b0);
		read_reg(ADDR_DECODED, "DECODED", 32'd0, 1'b0);
		read_reg(ADDR_ILLEGAL, "ILLEGAL", 32'd0, 1'b0);
		legal_cnt = 0;
		illegal_cnt = 0;
	endtask

	initial begin
		rng_state = SEED;
		ctrl_model = 2'b00;
		reset = 1'b1;
		fetch_valid = 1'b0;
		fetch_instr = 32'd0;
		dispatch_ready = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 4'd0;
		pwdata = 32'd0;
		repeat (3) @(posedge CLK);
		reset <= 1'b0;

		// decoder must stay idle until enabled
		@(negedge CLK);
		check_bit("dispatch_valid", 1'b0, dispatch_valid);
		check_bit("pslverr", 1'b0, pslverr);
		@(posedge CLK);
		fetch_valid <= 1'b1;
		fetch_instr <= 32'h0000_0013;
		repeat (20) begin
			@(negedge CLK);
			check_bit("fetch_ready", 1'b0, fetch_ready);
		end
		read_reg(ADDR_LEVEL, "LEVEL", 32'd0, 1'b0);
		read_reg(ADDR_CTRL, "CTRL", 32'd0, 1'b0);
		@(posedge CLK);
		fetch_valid <= 1'b0;

		write_reg(ADDR_CTRL, 32'h1, 1'b0);
		ctrl_model = 2'b01;
		run_stream(200, 0);
		drain();
		if (class_seen !== '1) begin
			$display("Stream did not exercise every operation class");
			other_errors++;
		end
		check_counters();

		// back-pressure
		run_stream(200, 1);
		drain();
		run_stream(FIFO_DEPTH, 2);
		read_reg(ADDR_LEVEL, "LEVEL", 32'(FIFO_DEPTH), 1'b0);
		@(posedge CLK);
		fetch_valid <= 1'b1;
		fetch_instr <= gen_word();
		repeat (5) begin
			@(negedge CLK);
			check_bit("fetch_ready", 1'b0, fetch_ready);
		end
		drain();
		check_counters();

		// illegal words dropped
		write_reg(ADDR_CTRL, 32'h3, 1'b0);
		ctrl_model = 2'b11;
		run_stream(150, 1);
		drain();
		check_counters();

		write_reg(ADDR_LEVEL, 32'h5, 1'b1);
		read_reg(4'h2, "offset 0x2", 32'd0, 1'b1);
		write_reg(4'h2, 32'h0, 1'b1);
		read_reg(ADDR_CTRL, "CTRL", 32'h3, 1'b0);
		finish_run();
	end

endmodule
